/* logic/btu_pkg.sv */
// ------------------------------------------------
// branch target unit package
// widths and sizes of the upper pc table and the
// compressed target table, vector typedefs and
// the update controller state enum
// ------------------------------------------------
`default_nettype none

package btu_pkg;

    // --------------------------------------------------
    // widths and sizes

    // upper pc bits kept once in the upct
    localparam int UPPER_PC_WIDTH = 10;
    // low target bits kept per slot
    localparam int LOWER_PC_WIDTH = 22;

    localparam int UPCT_ENTRIES     = 8;
    localparam int LOG_UPCT_ENTRIES = 3;

    localparam int CTT_ENTRIES     = 16;
    localparam int LOG_CTT_ENTRIES = 4;

    // --------------------------------------------------
    // vector types

    // full target is upper and lower joined
    typedef logic [UPPER_PC_WIDTH+LOWER_PC_WIDTH-1:0] pc_t;
    typedef logic [UPPER_PC_WIDTH-1:0]                upper_pc_t;
    typedef logic [LOWER_PC_WIDTH-1:0]                lower_pc_t;
    typedef logic [LOG_UPCT_ENTRIES-1:0]              upct_idx_t;
    typedef logic [LOG_CTT_ENTRIES-1:0]               ctt_slot_t;

    // write handshake FSM
    typedef enum logic [1:0] {
        IDLE,
        LOOKUP,
        ALLOC,
        WAIT_DROP
    } upd_state_t;

endpackage

`default_nettype wire

/* logic/pe_lsb.sv */
// ------------------------------------------------
// priority encoder
// index of the lowest set request bit
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module pe_lsb #(
    parameter int WIDTH = 8
) (
    input  logic [WIDTH-1:0]         req_vec,
    output logic [$clog2(WIDTH)-1:0] ack_index
);

    always_comb begin
        // zero when nothing is requested
        ack_index = '0;
        // walk down from the top bit
        // so the lowest set bit is the last one written
        for (int i = WIDTH - 1; i >= 0; i--) begin
            if (req_vec[i]) begin
                ack_index = i[$clog2(WIDTH)-1:0];
            end
        end
    end

endmodule

`default_nettype wire

/* logic/upct_plru.sv */
// ------------------------------------------------
// tree pseudo-LRU over the 8 upct ways
// three levels of tree bits, touch update
// and the victim index walked from the root
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module upct_plru (
    input  logic                CLK,
    input  logic                nRST,

    // way just used
    input  logic                touch_valid,
    input  btu_pkg::upct_idx_t  touch_index,

    // way to replace next
    output btu_pkg::upct_idx_t  victim_index
);

    // --------------------------------------------------
    // tree bits

    // root picks the half, index bit 2
    logic       root_q;
    // second level picks the quarter, indexed by bit 2
    logic [1:0] mid_q;
    // third level picks the way, indexed by bits 2:1
    logic [3:0] leaf_q;

    // --------------------------------------------------
    // victim walk

    // each bit points at the less recently used side
    assign victim_index = {
        root_q,
        mid_q[root_q],
        leaf_q[{root_q, mid_q[root_q]}]
    };

    // --------------------------------------------------
    // touch update

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            // all zero, victim is way 0
            root_q <= 1'b0;
            mid_q  <= '0;
            leaf_q <= '0;
        end else if (touch_valid) begin
            // every bit on the path points away from the touched way
            root_q                   <= ~touch_index[2];
            mid_q[touch_index[2]]    <= ~touch_index[1];
            leaf_q[touch_index[2:1]] <= ~touch_index[0];
        end
    end

endmodule

`default_nettype wire

/* logic/upct.sv */
// ------------------------------------------------
// upper pc table
// 8 entries of upper pc bits with a CAM lookup,
// a two-stage find-or-allocate update and the
// PLRU touch from reads of the target table
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module upct (
    input  logic                CLK,
    input  logic                nRST,

    // read response from the target table
    input  logic                read_valid_resp,
    input  btu_pkg::upct_idx_t  read_index_resp,

    output btu_pkg::upper_pc_t [btu_pkg::UPCT_ENTRIES-1:0] upct_array,

    // update stage 0 request
    input  logic                update0_valid,
    input  btu_pkg::pc_t        update0_target_full_pc,

    // update stage 1 result
    output btu_pkg::upct_idx_t  update1_upct_index
);

    // --------------------------------------------------
    // signals

    // stage 0
    btu_pkg::upper_pc_t                 upd0_upper;
    logic [btu_pkg::UPCT_ENTRIES-1:0]   upd0_match;

    // stage 1
    logic                               upd1_valid;
    btu_pkg::upper_pc_t                 upd1_upper;
    logic [btu_pkg::UPCT_ENTRIES-1:0]   upd1_match;
    logic                               upd1_hit;
    btu_pkg::upct_idx_t                 upd1_match_idx;

    // replacement
    logic                               touch_valid;
    btu_pkg::upct_idx_t                 touch_index;
    btu_pkg::upct_idx_t                 victim_index;

    // --------------------------------------------------
    // stage 0, CAM

    assign upd0_upper = update0_target_full_pc[
        btu_pkg::UPPER_PC_WIDTH+btu_pkg::LOWER_PC_WIDTH-1:btu_pkg::LOWER_PC_WIDTH];

    always_comb begin
        for (int i = 0; i < btu_pkg::UPCT_ENTRIES; i++) begin
            upd0_match[i] = (upct_array[i] == upd0_upper);
        end
    end

    // stage boundary, payload only
    always_ff @(posedge CLK) begin
        upd1_upper <= upd0_upper;
        upd1_match <= upd0_match;
    end

    // --------------------------------------------------
    // stage 1, hit or allocate

    assign upd1_hit = |upd1_match;

    // lowest matching entry wins on multiple hits
    pe_lsb #(
        .WIDTH(btu_pkg::UPCT_ENTRIES)
    ) u_match_pe (
        .req_vec   (upd1_match),
        .ack_index (upd1_match_idx)
    );

    // hit gives the match, anything else gives the victim
    assign update1_upct_index = (upd1_valid && upd1_hit) ? upd1_match_idx : victim_index;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            upd1_valid <= 1'b0;
            upct_array <= '0;
        end else begin
            upd1_valid <= update0_valid;
            // miss overwrites the victim entry
            if (upd1_valid && !upd1_hit) begin
                upct_array[victim_index] <= upd1_upper;
            end
        end
    end

    // --------------------------------------------------
    // PLRU

    // update stage 1 takes priority over a read touch
    assign touch_valid = upd1_valid || read_valid_resp;
    assign touch_index = upd1_valid ? update1_upct_index : read_index_resp;

    upct_plru u_plru (
        .CLK          (CLK),
        .nRST         (nRST),
        .touch_valid  (touch_valid),
        .touch_index  (touch_index),
        .victim_index (victim_index)
    );

endmodule

`default_nettype wire

/* logic/ctt_write_if.sv */
// ------------------------------------------------
// write port of the compressed target table
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

interface ctt_write_if;

    // write strobe, takes effect at the clock edge
    logic               valid;
    // slot being written
    btu_pkg::ctt_slot_t slot;
    // low target bits and the upct entry holding the rest
    btu_pkg::lower_pc_t lower_pc;
    btu_pkg::upct_idx_t upct_idx;

    // update controller side
    modport ctrl (output valid, output slot, output lower_pc, output upct_idx);

    // table side
    modport tbl (input valid, input slot, input lower_pc, input upct_idx);

endinterface

`default_nettype wire

/* logic/compressed_target_table.sv */
// ------------------------------------------------
// compressed target table
// 16 slots of low pc and upct index, one write
// port and a registered read that rebuilds the
// full target from the live upct contents
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module compressed_target_table (
    input  logic                CLK,
    input  logic                nRST,

    ctt_write_if.tbl            wr,

    // read request
    input  logic                rd_valid,
    input  btu_pkg::ctt_slot_t  rd_slot,

    input  btu_pkg::upper_pc_t [btu_pkg::UPCT_ENTRIES-1:0] upct_array,

    // registered read stage, also the upct touch
    output logic                read_valid_resp,
    output btu_pkg::upct_idx_t  read_index_resp,

    output logic                rd_target_valid,
    output btu_pkg::pc_t        rd_target
);

    // --------------------------------------------------
    // storage

    btu_pkg::lower_pc_t lower_mem [btu_pkg::CTT_ENTRIES];
    btu_pkg::upct_idx_t idx_mem   [btu_pkg::CTT_ENTRIES];

    // low pc of the slot being returned
    btu_pkg::lower_pc_t resp_lower;

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            // table starts out all zero
            for (int i = 0; i < btu_pkg::CTT_ENTRIES; i++) begin
                lower_mem[i] <= '0;
                idx_mem[i]   <= '0;
            end
        end else if (wr.valid) begin
            lower_mem[wr.slot] <= wr.lower_pc;
            idx_mem[wr.slot]   <= wr.upct_idx;
        end
    end

    // --------------------------------------------------
    // read stage

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            read_valid_resp <= 1'b0;
        end else begin
            read_valid_resp <= rd_valid;
        end
    end

    // read of a slot written at the same edge sees the old contents
    always_ff @(posedge CLK) begin
        resp_lower      <= lower_mem[rd_slot];
        read_index_resp <= idx_mem[rd_slot];
    end

    assign rd_target_valid = read_valid_resp;

    // upper bits come from the upct as it is now,
    // so a replaced entry shows its new value here
    assign rd_target = {upct_array[read_index_resp], resp_lower};

endmodule

`default_nettype wire

/* logic/target_update_ctrl.sv */
// ------------------------------------------------
// target update controller
// four-phase req/ack handshake that runs the
// upct update and then writes the target table
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module target_update_ctrl (
    input  logic                CLK,
    input  logic                nRST,

    // requester side
    input  logic                upd_req,
    input  btu_pkg::ctt_slot_t  upd_slot,
    input  btu_pkg::pc_t        upd_target,
    output logic                upd_ack,

    // upct update
    output logic                upd0_valid,
    output btu_pkg::pc_t        upd0_target,
    input  btu_pkg::upct_idx_t  update1_upct_index,

    // table write
    ctt_write_if.ctrl           wr
);

    // --------------------------------------------------
    // FSM

    btu_pkg::upd_state_t state_q;
    btu_pkg::upd_state_t state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            // wait for a request
            btu_pkg::IDLE: begin
                if (upd_req) begin
                    state_d = btu_pkg::LOOKUP;
                end
            end
            // upct stage 0 this cycle
            btu_pkg::LOOKUP: begin
                state_d = btu_pkg::ALLOC;
            end
            // upct stage 1 and table write this cycle
            btu_pkg::ALLOC: begin
                state_d = btu_pkg::WAIT_DROP;
            end
            // ack held until the request goes away
            btu_pkg::WAIT_DROP: begin
                if (!upd_req) begin
                    state_d = btu_pkg::IDLE;
                end
            end
            default: begin
                state_d = btu_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state_q <= btu_pkg::IDLE;
            upd_ack <= 1'b0;
        end else begin
            state_q <= state_d;
            // rises with the table write, drops a cycle after req low
            upd_ack <= (state_d == btu_pkg::WAIT_DROP);
        end
    end

    // --------------------------------------------------
    // outputs

    // requester holds the target stable, so it feeds the upct directly
    assign upd0_valid  = (state_q == btu_pkg::LOOKUP);
    assign upd0_target = upd_target;

    // stage 1 index is captured by the table at the end of ALLOC
    assign wr.valid    = (state_q == btu_pkg::ALLOC);
    assign wr.slot     = upd_slot;
    assign wr.lower_pc = upd_target[btu_pkg::LOWER_PC_WIDTH-1:0];
    assign wr.upct_idx = update1_upct_index;

endmodule

`default_nettype wire

/* logic/branch_target_unit.sv */
// ------------------------------------------------
// branch target unit top level
// update controller, upper pc table and the
// compressed target table
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module branch_target_unit (
    input  logic                CLK,
    input  logic                nRST,

    // write side, four-phase handshake
    input  logic                upd_req,
    input  btu_pkg::ctt_slot_t  upd_slot,
    input  btu_pkg::pc_t        upd_target,
    output logic                upd_ack,

    // read side
    input  logic                rd_valid,
    input  btu_pkg::ctt_slot_t  rd_slot,
    output logic                rd_target_valid,
    output btu_pkg::pc_t        rd_target
);

    // --------------------------------------------------
    // internal wires

    // controller to upct
    logic                upd0_valid;
    btu_pkg::pc_t        upd0_target;
    btu_pkg::upct_idx_t  update1_upct_index;

    // table to upct
    logic                read_valid_resp;
    btu_pkg::upct_idx_t  read_index_resp;
    btu_pkg::upper_pc_t [btu_pkg::UPCT_ENTRIES-1:0] upct_array;

    // controller to table
    ctt_write_if wr_if ();

    // --------------------------------------------------
    // instances

    target_update_ctrl u_ctrl (
        .CLK                (CLK),
        .nRST               (nRST),
        .upd_req            (upd_req),
        .upd_slot           (upd_slot),
        .upd_target         (upd_target),
        .upd_ack            (upd_ack),
        .upd0_valid         (upd0_valid),
        .upd0_target        (upd0_target),
        .update1_upct_index (update1_upct_index),
        .wr                 (wr_if.ctrl)
    );

    upct u_upct (
        .CLK                    (CLK),
        .nRST                   (nRST),
        .read_valid_resp        (read_valid_resp),
        .read_index_resp        (read_index_resp),
        .upct_array             (upct_array),
        .update0_valid          (upd0_valid),
        .update0_target_full_pc (upd0_target),
        .update1_upct_index     (update1_upct_index)
    );

    compressed_target_table u_ctt (
        .CLK             (CLK),
        .nRST            (nRST),
        .wr              (wr_if.tbl),
        .rd_valid        (rd_valid),
        .rd_slot         (rd_slot),
        .upct_array      (upct_array),
        .read_valid_resp (read_valid_resp),
        .read_index_resp (read_index_resp),
        .rd_target_valid (rd_target_valid),
        .rd_target       (rd_target)
    );

endmodule

`default_nettype wire

/* tb/tb_clock_gen.sv */
// ------------------------------------------------
// testbench clock and reset
// 8 ns clock, reset low for the first 2 cycles
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
    output logic CLK,
    output logic nRST
);

    // half period of 4 ns
    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        nRST = 1'b0;
        repeat (2) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;
    end

endmodule

`default_nettype wire

/* tb/tb_branch_target_unit.sv */
// ------------------------------------------------
// branch target unit testbench
// directed and random writes and reads, a cycle
// model of the upct, PLRU and table, compare
// tasks and a cycle timeout
// ------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_branch_target_unit;

    logic                CLK;
    logic                nRST;
    logic                upd_req;
    btu_pkg::ctt_slot_t  upd_slot;
    btu_pkg::pc_t        upd_target;
    logic                upd_ack;
    logic                rd_valid;
    btu_pkg::ctt_slot_t  rd_slot;
    logic                rd_target_valid;
    btu_pkg::pc_t        rd_target;

    // --------------------------------------------------
    // model state

    btu_pkg::upper_pc_t m_upper [btu_pkg::UPCT_ENTRIES];
    btu_pkg::lower_pc_t m_lower [btu_pkg::CTT_ENTRIES];
    btu_pkg::upct_idx_t m_idx   [btu_pkg::CTT_ENTRIES];
    // tree bits in heap order, node 0 is the root
    bit                 m_tree  [7];
    // handshake phase: idle, lookup, alloc, waiting for drop
    int                 m_phase;
    logic               m_ack;
    // read response in flight
    logic               m_rv;
    btu_pkg::lower_pc_t m_rlower;
    btu_pkg::upct_idx_t m_ridx;

    // small pool of upper values, so hits and evictions both happen
    btu_pkg::upper_pc_t pool [12];
    integer             seed;
    int                 cycles;
    int                 num_random = 400;
    // directed part stays under 200 cycles, a random op takes at most 4
    int                 timeout_cycles = 4 * (200 + 4 * 400);

    tb_clock_gen i_clk_gen (.CLK(CLK), .nRST(nRST));

    branch_target_unit i_dut (
        .CLK             (CLK),
        .nRST            (nRST),
        .upd_req         (upd_req),
        .upd_slot        (upd_slot),
        .upd_target      (upd_target),
        .upd_ack         (upd_ack),
        .rd_valid        (rd_valid),
        .rd_slot         (rd_slot),
        .rd_target_valid (rd_target_valid),
        .rd_target       (rd_target)
    );

    // --------------------------------------------------
    // compare tasks

    task automatic stop_on_error();
        $display("TESTS FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_bit(input string name, input logic actual, input logic expected);
        if (actual !== expected) begin
            $display("** Error: %s is %h, expected %h", name, actual, expected);
            stop_on_error();
        end
    endtask

    task automatic check_target(input string name, input btu_pkg::pc_t actual,
                                input btu_pkg::pc_t expected);
        if (actual !== expected) begin
            $display("** Error: %s is %h, expected %h", name, actual, expected);
            stop_on_error();
        end
    endtask

    // --------------------------------------------------
    // reference model

    // follow the tree bits down from the root
    function automatic btu_pkg::upct_idx_t tree_victim();
        int                 n;
        btu_pkg::upct_idx_t v;
        n = 0;
        v = '0;
        for (int lvl = 0; lvl < 3; lvl++) begin
            v = {v[1:0], m_tree[n]};
            n = m_tree[n] ? 2 * n + 2 : 2 * n + 1;
        end
        return v;
    endfunction

    // every node on the path points away from the used way
    function automatic void tree_touch(input btu_pkg::upct_idx_t idx);
        int                 n;
        btu_pkg::upct_idx_t rest;
        n = 0;
        rest = idx;
        for (int lvl = 0; lvl < 3; lvl++) begin
            m_tree[n] = !rest[2];
            n = rest[2] ? 2 * n + 2 : 2 * n + 1;
            rest = rest << 1;
        end
    endfunction

    function automatic btu_pkg::pc_t model_target(input btu_pkg::ctt_slot_t slot);
        return {m_upper[m_idx[slot]], m_lower[slot]};
    endfunction

    // effect of the coming rising edge on the model
    function automatic void model_edge();
        btu_pkg::lower_pc_t nxt_lower;
        btu_pkg::upct_idx_t nxt_idx;
        btu_pkg::upper_pc_t up;
        btu_pkg::upct_idx_t use_idx;
        bit                 found;
        // a read sees the table before a write at the same edge
        nxt_lower = m_lower[rd_slot];
        nxt_idx   = m_idx[rd_slot];
        if (m_phase == 2) begin
            up = upd_target[btu_pkg::LOWER_PC_WIDTH +: btu_pkg::UPPER_PC_WIDTH];
            found = 1'b0;
            use_idx = '0;
            // lowest matching entry
            for (int i = 0; i < btu_pkg::UPCT_ENTRIES; i++) begin
                if (!found && m_upper[i] == up) begin
                    found = 1'b1;
                    use_idx = btu_pkg::upct_idx_t'(i);
                end
            end
            if (!found) begin
                use_idx = tree_victim();
                m_upper[use_idx] = up;
            end
            m_lower[upd_slot] = upd_target[btu_pkg::LOWER_PC_WIDTH-1:0];
            m_idx[upd_slot]   = use_idx;
            // update wins, a read touch in this cycle is lost
            tree_touch(use_idx);
        end else if (m_rv) begin
            tree_touch(m_ridx);
        end
        case (m_phase)
            0: m_phase = upd_req ? 1 : 0;
            1: m_phase = 2;
            2: begin
                m_phase = 3;
                m_ack   = 1'b1;
            end
            default: begin
                if (!upd_req) begin
                    m_phase = 0;
                    m_ack   = 1'b0;
                end
            end
        endcase
        m_rv     = rd_valid;
        m_rlower = nxt_lower;
        m_ridx   = nxt_idx;
    endfunction

    // --------------------------------------------------
    // stimulus

    // one clock, checked on the next falling edge
    task automatic run_cycle();
        model_edge();
        @(negedge CLK);
        check_bit("upd_ack", upd_ack, m_ack);
        check_bit("rd_target_valid", rd_target_valid, m_rv);
        if (m_rv) begin
            check_target("rd_target", rd_target, {m_upper[m_ridx], m_rlower});
        end
    endtask

    task automatic pick_read(input int rate);
        rd_valid = ({$random(seed)} % 100) < rate;
        rd_slot  = btu_pkg::ctt_slot_t'($random(seed));
    endtask

    task automatic idle(input int n);
        rd_valid = 1'b0;
        repeat (n) run_cycle();
    endtask

    // full four-phase handshake, optional reads alongside
    task automatic write_target(input btu_pkg::ctt_slot_t slot, input btu_pkg::pc_t target,
                                input int rate);
        upd_req    = 1'b1;
        upd_slot   = slot;
        upd_target = target;
        do begin
            pick_read(rate);
            run_cycle();
        end while (!upd_ack);
        upd_req = 1'b0;
        do begin
            pick_read(rate);
            run_cycle();
        end while (upd_ack);
        rd_valid = 1'b0;
    endtask

    task automatic read_expect(input btu_pkg::ctt_slot_t slot, input btu_pkg::pc_t expected);
        rd_valid = 1'b1;
        rd_slot  = slot;
        run_cycle();
        rd_valid = 1'b0;
        check_bit("rd_target_valid", rd_target_valid, 1'b1);
        check_target("rd_target", rd_target, expected);
    endtask

    task automatic read_all();
        for (int s = 0; s < btu_pkg::CTT_ENTRIES; s++) begin
            read_expect(btu_pkg::ctt_slot_t'(s), model_target(btu_pkg::ctt_slot_t'(s)));
        end
    endtask

    function automatic btu_pkg::pc_t random_target();
        int k;
        k = {$random(seed)} % 12;
        return {pool[k], btu_pkg::lower_pc_t'($random(seed))};
    endfunction

    // --------------------------------------------------
    // cycle limit

    always @(posedge CLK) begin
        cycles = cycles + 1;
        if (cycles >= timeout_cycles) begin
            $display("timeout after %0d cycles without finishing", cycles);
            stop_on_error();
        end
    end

    // --------------------------------------------------
    // test sequence

    initial begin
        btu_pkg::pc_t t;
        int           sel;
        seed       = 32'hc691944f;
        cycles     = 0;
        upd_req    = 1'b0;
        upd_slot   = '0;
        upd_target = '0;
        rd_valid   = 1'b0;
        rd_slot    = '0;
        // model matches the reset state
        foreach (m_upper[i]) m_upper[i] = '0;
        foreach (m_lower[i]) m_lower[i] = '0;
        foreach (m_idx[i]) m_idx[i] = '0;
        foreach (m_tree[i]) m_tree[i] = 1'b0;
        foreach (pool[i]) pool[i] = btu_pkg::upper_pc_t'(37 * i + 5);
        m_phase  = 0;
        m_ack    = 1'b0;
        m_rv     = 1'b0;
        m_rlower = '0;
        m_ridx   = '0;
        @(posedge nRST);

        // every slot reads zero after reset
        for (int s = 0; s < btu_pkg::CTT_ENTRIES; s++) begin
            read_expect(btu_pkg::ctt_slot_t'(s), '0);
        end

        // single write, then read back
        t = {pool[0], 22'h2bc1d5};
        write_target(4'd3, t, 0);
        read_expect(4'd3, t);

        // same upper bits share one entry
        write_target(4'd7, {pool[0], 22'h01a2b3}, 0);
        read_expect(4'd7, {pool[0], 22'h01a2b3});
        read_expect(4'd3, t);
        read_all();

        // all 12 pool uppers, more than entries, stale slots follow the model
        for (int k = 0; k < 12; k++) begin
            write_target(btu_pkg::ctt_slot_t'(k),
                         {pool[k], btu_pkg::lower_pc_t'($random(seed))}, 0);
        end
        read_all();

        // reads every cycle, some land on update stage 1
        repeat (8) write_target(btu_pkg::ctt_slot_t'($random(seed)), random_target(), 100);
        read_all();

        // random mix with idle gaps
        repeat (num_random) begin
            sel = {$random(seed)} % 4;
            case (sel)
                0, 1: write_target(btu_pkg::ctt_slot_t'($random(seed)), random_target(), 30);
                2: begin
                    pick_read(100);
                    run_cycle();
                    rd_valid = 1'b0;
                end
                default: idle(1 + {$random(seed)} % 3);
            endcase
        end
        idle(2);

        $display("TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

/* project.f */
logic/btu_pkg.sv
logic/pe_lsb.sv
logic/upct_plru.sv
logic/upct.sv
logic/ctt_write_if.sv
logic/compressed_target_table.sv
logic/target_update_ctrl.sv
logic/branch_target_unit.sv
tb/tb_clock_gen.sv
tb/tb_branch_target_unit.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the branch target unit testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -j 0 --top-module tb_branch_target_unit \
    -f project.f -o sim_btu > sim.log 2>&1 \
    && ./obj_dir/sim_btu >> sim.log 2>&1 \
    || echo "build or simulation exited with an error" >> sim.log

cat sim.log
grep -q "TESTS FAILED" sim.log && { echo "result: failed"; exit 1; }
grep -q "TESTS PASSED" sim.log || { echo "result: no pass line in the log"; exit 1; }
echo "result: passed"
